// File: spi_pkg.sv
// Shared definitions for the SPI minion bridge.
// Frame and payload sizes, queue depth and free-count width.
// Frame union with the push (received) and pull (transmit) views.

package spi_pkg;

  localparam int FRAME_BITS  = 10;  // Two flag bits plus payload.
  localparam int DATA_BITS   = 8;   // Payload byte.
  localparam int QUEUE_DEPTH = 2;   // Entries per message queue.
  localparam int FREE_BITS   = 2;   // Holds 0 to QUEUE_DEPTH.

  // One shift-register word, read two ways.
  // The host's frame arrives in the push view; the reply is built in the pull view.
  typedef union packed {
    struct packed {
      logic                 val_wrt;  // Host writes data into the mc queue.
      logic                 val_rd;   // Host asks for a byte from the cm queue.
      logic [DATA_BITS-1:0] data;     // Byte written by the host.
    } push;
    struct packed {
      logic                 spc;      // Room left in the mc queue.
      logic                 val;      // Data holds a popped byte.
      logic [DATA_BITS-1:0] data;     // Byte returned to the host.
    } pull;
  } spi_frame_u;

endpackage

// File: spi_shift_stage.sv
// SPI shift stage.
// Two-flop pin synchronizer, sclk and cs edge detection,
// frame shift register with miso output and frame-end strobes.

module spi_shift_stage
  import spi_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       sclk,
  input  logic       cs,
  input  logic       mosi,
  input  spi_frame_u pull_frame,
  output logic       miso,
  output logic       push_en,
  output logic       pull_en,
  output spi_frame_u push_frame
);

  logic [1:0]            sclk_sync;     // Synchronizer chains, bit 1 is stable.
  logic [1:0]            cs_sync;
  logic [1:0]            mosi_sync;
  logic                  sclk_prev;     // Edge-detect history.
  logic                  cs_prev;
  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  cs_rise;
  logic                  cs_active;
  logic                  frame_strobe;
  logic [FRAME_BITS-1:0] shift_reg;

  // Pin synchronizer and edge history.
  always_ff @(posedge clk) begin
    if (reset) begin
      sclk_sync <= 2'b00;
      cs_sync   <= 2'b11;               // Chip select idles high.
      mosi_sync <= 2'b00;
      sclk_prev <= 1'b0;
      cs_prev   <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_prev <= sclk_sync[1];
      cs_prev   <= cs_sync[1];
    end
  end

  always_comb begin
    cs_active = ~cs_sync[1];                  // Active low select.
    sclk_rise = cs_active & sclk_sync[1] & ~sclk_prev;
    sclk_fall = cs_active & ~sclk_sync[1] & sclk_prev;
    cs_rise   = cs_sync[1] & ~cs_prev;        // End of a frame.
  end

  // One strobe per frame end, shared by push and pull.
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_strobe <= 1'b0;
    end else begin
      frame_strobe <= cs_rise;
    end
  end

  // Shift in on rising sclk; reload with the reply at frame end.
  always_ff @(posedge clk) begin
    if (reset) begin
      shift_reg <= '0;
    end else if (frame_strobe) begin
      shift_reg <= pull_frame;
    end else if (sclk_rise) begin
      shift_reg <= {shift_reg[FRAME_BITS-2:0], mosi_sync[1]};
    end
  end

  // The first bit goes out at reload, the rest on falling sclk.
  always_ff @(posedge clk) begin
    if (reset) begin
      miso <= 1'b0;
    end else if (frame_strobe) begin
      miso <= pull_frame.pull.spc;            // MSB of the next reply.
    end else if (sclk_fall) begin
      miso <= shift_reg[FRAME_BITS-1];
    end
  end

  assign push_en    = frame_strobe;
  assign pull_en    = frame_strobe;
  assign push_frame = shift_reg;              // Still the received frame during the strobe.

endmodule

// File: msg_queue.sv
// Message queue for the bridge.
// Circular buffer of QUEUE_DEPTH bytes with val/rdy on both sides
// and a free-entry count.

module msg_queue
  import spi_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [DATA_BITS-1:0] recv_msg,
  input  logic                 recv_val,
  output logic                 recv_rdy,
  output logic [DATA_BITS-1:0] send_msg,
  output logic                 send_val,
  input  logic                 send_rdy,
  output logic [FREE_BITS-1:0] num_free
);

  logic [DATA_BITS-1:0]           mem [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
  logic [FREE_BITS-1:0]           count;
  logic                           do_enq;
  logic                           do_deq;

  assign recv_rdy = (count != FREE_BITS'(QUEUE_DEPTH));  // No bypass when full.
  assign send_val = (count != '0);
  assign send_msg = mem[rd_ptr];
  assign num_free = FREE_BITS'(QUEUE_DEPTH) - count;

  assign do_enq = recv_val & recv_rdy;
  assign do_deq = send_val & send_rdy;

  // Storage.
  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= recv_msg;
    end
  end

  // Pointers and occupancy.
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= (wr_ptr == ($clog2(QUEUE_DEPTH))'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_deq) begin
        rd_ptr <= (rd_ptr == ($clog2(QUEUE_DEPTH))'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_enq && !do_deq) begin
        count <= count + 1'b1;
      end else if (do_deq && !do_enq) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: spi_minion_adapter.sv
// Minion adapter.
// Turns frame-end push and pull strobes into queue val/rdy traffic,
// builds the reply frame and forms the send-side parity.

module spi_minion_adapter
  import spi_pkg::*;
(
  input  logic                 push_en,
  input  logic                 pull_en,
  input  spi_frame_u           push_frame,
  input  logic [FREE_BITS-1:0] mc_num_free,
  input  logic                 mc_recv_rdy,
  input  logic [DATA_BITS-1:0] cm_send_msg,
  input  logic                 cm_send_val,
  input  logic [DATA_BITS-1:0] send_msg,
  input  logic                 send_val,
  output spi_frame_u           pull_frame,
  output logic                 mc_recv_val,
  output logic                 cm_send_rdy,
  output logic                 parity
);

  logic open_entries;   // More than one mc slot free.
  logic popped;

  always_comb begin
    open_entries = (mc_num_free > FREE_BITS'(1));
    mc_recv_val  = push_en & push_frame.push.val_wrt;     // Dropped by the queue when full.
    cm_send_rdy  = push_en & pull_en & push_frame.push.val_rd;
    popped       = cm_send_rdy & cm_send_val;

    // Space remains after this frame's write, if it has one.
    pull_frame.pull.spc  = mc_recv_rdy & (~mc_recv_val | open_entries);
    pull_frame.pull.val  = popped;
    pull_frame.pull.data = cm_send_msg & {DATA_BITS{popped}};  // Zero when nothing popped.
  end

  assign parity = (^send_msg) & send_val;   // Even parity of the waiting byte.

endmodule

// File: spi_minion_top.sv
// SPI minion bridge top level.
// Shift stage, minion adapter and the two message queues.

module spi_minion_top
  import spi_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 sclk,
  input  logic                 cs,
  input  logic                 mosi,
  output logic                 miso,
  input  logic [DATA_BITS-1:0] recv_msg,
  input  logic                 recv_val,
  output logic                 recv_rdy,
  output logic [DATA_BITS-1:0] send_msg,
  output logic                 send_val,
  input  logic                 send_rdy,
  output logic                 parity
);

  logic                 push_en;
  logic                 pull_en;
  spi_frame_u           push_frame;
  spi_frame_u           pull_frame;
  logic [FREE_BITS-1:0] mc_num_free;
  logic                 mc_recv_val;
  logic                 mc_recv_rdy;
  logic [DATA_BITS-1:0] cm_send_msg;
  logic                 cm_send_val;
  logic                 cm_send_rdy;

  spi_shift_stage shift_i (
    .clk        (clk),
    .reset      (reset),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .pull_frame (pull_frame),
    .miso       (miso),
    .push_en    (push_en),
    .pull_en    (pull_en),
    .push_frame (push_frame)
  );

  spi_minion_adapter adapter_i (
    .push_en     (push_en),
    .pull_en     (pull_en),
    .push_frame  (push_frame),
    .mc_num_free (mc_num_free),
    .mc_recv_rdy (mc_recv_rdy),
    .cm_send_msg (cm_send_msg),
    .cm_send_val (cm_send_val),
    .send_msg    (send_msg),
    .send_val    (send_val),
    .pull_frame  (pull_frame),
    .mc_recv_val (mc_recv_val),
    .cm_send_rdy (cm_send_rdy),
    .parity      (parity)
  );

  // Controller to minion, read by the host.
  msg_queue cm_q (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (cm_send_msg),
    .send_val (cm_send_val),
    .send_rdy (cm_send_rdy),
    .num_free ()
  );

  // Minion to controller, written by the host.
  msg_queue mc_q (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (push_frame.push.data),
    .recv_val (mc_recv_val),
    .recv_rdy (mc_recv_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .num_free (mc_num_free)
  );

endmodule

// File: tb_spi_minion.sv
// Testbench for the SPI minion bridge.
// SPI host driver, byte-queue reference model and compare tasks.
// Directed write, read, space and back-pressure tests, then mixed random traffic.

module tb_spi_minion
  import spi_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_CLKS  = 6;     // sclk half-period in clk cycles.
  localparam int WAIT_LIMIT = 400;   // Cycle limit for a single wait.
  localparam int MIX_FRAMES = 200;

  logic                 clk;
  logic                 reset;
  logic                 sclk;
  logic                 cs;
  logic                 mosi;
  logic                 miso;
  logic [DATA_BITS-1:0] recv_msg;
  logic                 recv_val;
  logic                 recv_rdy;
  logic [DATA_BITS-1:0] send_msg;
  logic                 send_val;
  logic                 send_rdy;
  logic                 parity;

  // Model state, updated only by the monitor.
  logic [DATA_BITS-1:0] cm_model[$];
  logic [DATA_BITS-1:0] mc_model[$];
  spi_frame_u           reply_model = '0;   // Reply the next frame shifts out.
  int                   delivered = 0;      // Send handshakes seen on the DUT ports.
  int                   strobe_ack = 0;

  // Host side requests.
  spi_frame_u           frame_pending = '0;
  int                   strobe_req = 0;
  logic                 checking;
  logic                 mixing_done;
  string                test_name;
  spi_frame_u           mix_frames [MIX_FRAMES];

  spi_minion_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .sclk     (sclk),
    .cs       (cs),
    .mosi     (mosi),
    .miso     (miso),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .parity   (parity)
  );

  always begin
    clk = 1'b0;
    #50;
    clk = 1'b1;
    #50;
  end

  task automatic fail_run();
    $display("test failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic timed_out(input string what);
    $display("Timed out in %s while waiting for %s.", test_name, what);
    fail_run();
  endtask

  task automatic check_frame(input string what, input spi_frame_u act, input spi_frame_u exp);
    if (act !== exp) begin
      $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
      fail_run();
    end
  endtask

  task automatic check_byte(input string what, input logic [DATA_BITS-1:0] act,
                            input logic [DATA_BITS-1:0] exp);
    if (act !== exp) begin
      $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
      fail_run();
    end
  endtask

  task automatic check_bit(input string what, input logic act, input logic exp);
    if (act !== exp) begin
      $display("ERR %s %s: expected %b actual %b", test_name, what, exp, act);
      fail_run();
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk);
  endtask

  function automatic spi_frame_u make_frame(input logic wrt, input logic rd,
                                            input logic [DATA_BITS-1:0] data);
    spi_frame_u f;
    f.push.val_wrt = wrt;
    f.push.val_rd  = rd;
    f.push.data    = data;
    return f;
  endfunction

  // One SPI transaction, MSB first; miso is sampled at the end of each low phase.
  task automatic host_frame(input spi_frame_u tx, output spi_frame_u rx);
    spi_frame_u expected;
    int         k;
    int         waited;
    expected = reply_model;
    @(posedge clk);
    cs <= 1'b0;
    for (k = FRAME_BITS - 1; k >= 0; k--) begin
      mosi <= tx[k];                    // Changes while sclk is low.
      idle(HALF_CLKS - 1);
      @(negedge clk);
      rx[k] = miso;
      @(posedge clk);
      sclk <= 1'b1;
      idle(HALF_CLKS);
      sclk <= 1'b0;
    end
    idle(HALF_CLKS);
    cs <= 1'b1;
    idle(3);                            // Strobe is high from here for one cycle.
    frame_pending = tx;
    strobe_req++;
    waited = 0;
    while (strobe_ack != strobe_req) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out("the frame-end model update");
      end
    end
    idle(4);
    check_frame("miso frame", rx, expected);
  endtask

  task automatic load_byte(input logic [DATA_BITS-1:0] b);
    int waited;
    waited = 0;
    @(posedge clk);
    recv_msg <= b;
    recv_val <= 1'b1;
    @(negedge clk);
    while (!recv_rdy) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out("recv_rdy");
      end
    end
    @(posedge clk);
    recv_val <= 1'b0;
  endtask

  task automatic wait_mc_empty();
    int waited;
    waited = 0;
    while (mc_model.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out("the send port to drain");
      end
    end
    idle(2);
  endtask

  task automatic drive_random_ports();
    int cycles;
    cycles = 0;
    while (!mixing_done) begin
      @(posedge clk);
      recv_val <= ($urandom % 4) == 0;
      recv_msg <= 8'($urandom);
      send_rdy <= 1'($urandom);
      cycles++;
      if (cycles > MIX_FRAMES * 200) begin
        timed_out("the mixed frame sequence");
      end
    end
    recv_val <= 1'b0;
    send_rdy <= 1'b1;
  endtask

  // Samples at the falling clock edge, where ports are stable for the next rising edge.
  always @(negedge clk) begin
    logic       deq;
    logic       enq;
    int         free;
    spi_frame_u reply;
    if (checking) begin
      check_bit("recv_rdy", recv_rdy, cm_model.size() < QUEUE_DEPTH);
      check_bit("send_val", send_val, mc_model.size() != 0);
      if (mc_model.size() != 0) begin
        check_byte("send_msg", send_msg, mc_model[0]);
        check_bit("parity", parity, ^mc_model[0]);
      end else begin
        check_bit("parity", parity, 1'b0);
      end
      deq = send_rdy && (mc_model.size() != 0);
      enq = recv_val && (cm_model.size() < QUEUE_DEPTH);
      if (strobe_ack != strobe_req) begin
        reply = '0;
        if (frame_pending.push.val_rd && cm_model.size() != 0) begin
          reply.pull.val  = 1'b1;
          reply.pull.data = cm_model.pop_front();
        end
        free = QUEUE_DEPTH - mc_model.size();
        if (frame_pending.push.val_wrt && free > 0) begin
          mc_model.push_back(frame_pending.push.data);
          free--;
        end
        reply.pull.spc = (free > 0);    // Room left after this write.
        reply_model    = reply;
        strobe_ack     = strobe_req;
      end
      if (send_val && send_rdy) begin
        delivered++;
      end
      if (deq) begin
        void'(mc_model.pop_front());
      end
      if (enq) begin
        cm_model.push_back(recv_msg);
      end
    end
  end

  initial begin
    spi_frame_u rx;
    int         base;
    int         i;
    void'($urandom(49));
    reset    <= 1'b1;
    sclk     <= 1'b0;
    cs       <= 1'b1;
    mosi     <= 1'b0;
    recv_msg <= '0;
    recv_val <= 1'b0;
    send_rdy <= 1'b0;
    checking    = 1'b0;
    mixing_done = 1'b0;
    test_name   = "reset";
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    checking = 1'b1;                    // Parity is checked every cycle from here on.

    test_name = "write path";
    send_rdy <= 1'b1;
    base = delivered;
    for (i = 0; i < 8; i++) begin
      host_frame(make_frame(1'b1, 1'b0, 8'($urandom)), rx);
    end
    wait_mc_empty();
    check_byte("bytes delivered", DATA_BITS'(delivered - base), 8'd8);

    test_name = "read path";
    load_byte(8'($urandom));
    load_byte(8'($urandom));
    for (i = 0; i < 3; i++) begin
      host_frame(make_frame(1'b0, 1'b1, 8'h00), rx);
    end
    host_frame(make_frame(1'b0, 1'b0, 8'h00), rx);
    check_bit("val of empty read", rx.pull.val, 1'b0);
    check_byte("data of empty read", rx.pull.data, 8'h00);

    test_name = "space flag";
    send_rdy <= 1'b0;
    base = delivered;
    host_frame(make_frame(1'b1, 1'b0, 8'($urandom)), rx);
    host_frame(make_frame(1'b1, 1'b0, 8'($urandom)), rx);
    check_bit("spc after first write", rx.pull.spc, 1'b1);
    host_frame(make_frame(1'b1, 1'b0, 8'($urandom)), rx);
    check_bit("spc after second write", rx.pull.spc, 1'b0);
    host_frame(make_frame(1'b0, 1'b0, 8'h00), rx);
    check_bit("spc after dropped write", rx.pull.spc, 1'b0);
    send_rdy <= 1'b1;
    wait_mc_empty();
    check_byte("bytes delivered", DATA_BITS'(delivered - base), 8'd2);

    test_name = "recv back-pressure";
    load_byte(8'($urandom));
    load_byte(8'($urandom));
    @(negedge clk);
    check_bit("recv_rdy when full", recv_rdy, 1'b0);
    host_frame(make_frame(1'b0, 1'b1, 8'h00), rx);
    @(negedge clk);
    check_bit("recv_rdy after one read", recv_rdy, 1'b1);
    host_frame(make_frame(1'b0, 1'b1, 8'h00), rx);

    test_name = "mixed traffic";
    for (i = 0; i < MIX_FRAMES; i++) begin
      mix_frames[i] = make_frame(1'($urandom), 1'($urandom), 8'($urandom));
    end
    fork
      begin
        for (i = 0; i < MIX_FRAMES; i++) begin
          host_frame(mix_frames[i], rx);
        end
        mixing_done = 1'b1;
      end
      begin
        drive_random_ports();
      end
    join
    wait_mc_empty();

    $display("test passed");
    $finish;
  end

endmodule

// File: vlog.f
spi_pkg.sv
spi_shift_stage.sv
msg_queue.sv
spi_minion_adapter.sv
spi_minion_top.sv
tb_spi_minion.sv

// File: run.sh
#!/bin/sh
# Build the SPI minion bridge testbench with Verilator and run it.
# Pass or fail is taken from the simulation output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_spi_minion \
  -f vlog.f -o tb_spi_minion_sim \
  && ./obj_dir/tb_spi_minion_sim | tee /dev/stderr | grep -x "test passed" > /dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
